/* data_mem.sv */
`include "lsu_config.svh"

module data_mem (
  input  logic               clk,
  input  logic               rst_n,
  input  lsu_pkg::mem_wr_t   mem_wr,
  input  logic [`LSU_AW-1:0] rd_addr,
  output logic [31:0]        rdata_word
);
  localparam int DEPTH = 2 ** `LSU_AW;

  // Word-organized storage, one entry per 32-bit word
  logic [31:0] mem [DEPTH];

  // Start from a known all-zero image
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'h0;
    end
  end

  // Registered read with one cycle of latency
  // Nonblocking update returns the old word on a same-edge write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata_word <= 32'h0;
    end else begin
      rdata_word <= mem[rd_addr];
    end
  end

  // Write port with per-byte strobes
  // Reset wipes every word back to zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= 32'h0;
      end
    end else if (mem_wr.we) begin
      for (int b = 0; b < 4; b++) begin
        // Untouched lanes keep their old bytes
        if (mem_wr.wstrb[b]) begin
          mem[mem_wr.word_addr][b*8 +: 8] <= mem_wr.wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

/* load_extract.sv */
module load_extract (
  input  lsu_pkg::load_ctx_t load_ctx,
  input  logic [31:0]        rdata_word,
  output lsu_pkg::lsu_rsp_t  rsp
);
  import lsu_pkg::*;

  logic [31:0] shifted;
  logic [31:0] extended;
  logic        keep_data;

  // Move the addressed lane down to bit 0
  assign shifted = rdata_word >> {load_ctx.offset, 3'b000};

  // Mask to the access size, then sign- or zero-extend
  always_comb begin
    unique case (load_ctx.size)
      BYTE: begin
        if (load_ctx.is_unsigned) begin
          extended = {24'h0, shifted[7:0]};
        end else begin
          extended = {{24{shifted[7]}}, shifted[7:0]};
        end
      end
      HALF: begin
        if (load_ctx.is_unsigned) begin
          extended = {16'h0, shifted[15:0]};
        end else begin
          extended = {{16{shifted[15]}}, shifted[15:0]};
        end
      end
      WORD: begin
        extended = shifted;
      end
      default: begin
        extended = 32'h0;
      end
    endcase
  end

  // Stores, refused requests and idle cycles return zero
  assign keep_data = load_ctx.valid && load_ctx.is_load && !load_ctx.err;

  always_comb begin
    rsp.valid = load_ctx.valid;
    rsp.err   = load_ctx.err;
    rsp.rdata = keep_data ? extended : 32'h0;
  end

endmodule

/* lsu.f */
+incdir+.
lsu_pkg.sv
lsu_ctrl.sv
store_align.sv
data_mem.sv
load_extract.sv
lsu_top.sv
tb_lsu.sv

/* lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Build-time parameters of the load/store unit

// Word-address width of the data memory
// 10 gives 1024 words of 32 bits or 4 KiB in total
// Byte addresses carry two extra bits below this
`define LSU_AW 10

// Base slack in cycles for the simulation timeout
// The testbench adds a multiple of its request count
`define LSU_TIMEOUT_BASE 100

`endif

/* lsu_ctrl.sv */
`include "lsu_config.svh"

module lsu_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  lsu_pkg::lsu_req_t    req,
  output logic                 st_en,
  output lsu_pkg::access_size_e st_size,
  output logic [1:0]           st_offset,
  output logic [31:0]          st_wdata,
  output logic [`LSU_AW-1:0]   word_addr,
  output lsu_pkg::load_ctx_t   load_ctx
);
  import lsu_pkg::*;

  access_size_e size;
  logic         is_load;
  logic         is_store;
  logic         is_unsigned;
  logic [1:0]   offset;
  logic         misaligned;

  // Split the byte address into word index and lane offset
  assign word_addr = req.addr[`LSU_AW+1:2];
  assign offset    = req.addr[1:0];

  // Opcode decode into size, direction and signedness
  always_comb begin
    size        = WORD;
    is_load     = 1'b0;
    is_store    = 1'b0;
    is_unsigned = 1'b0;
    unique case (req.op)
      LB: begin
        size    = BYTE;
        is_load = 1'b1;
      end
      LH: begin
        size    = HALF;
        is_load = 1'b1;
      end
      LW: begin
        size    = WORD;
        is_load = 1'b1;
      end
      LBU: begin
        size        = BYTE;
        is_load     = 1'b1;
        is_unsigned = 1'b1;
      end
      LHU: begin
        size        = HALF;
        is_load     = 1'b1;
        is_unsigned = 1'b1;
      end
      SB: begin
        size     = BYTE;
        is_store = 1'b1;
      end
      SH: begin
        size     = HALF;
        is_store = 1'b1;
      end
      SW: begin
        size     = WORD;
        is_store = 1'b1;
      end
      default: begin
        size = WORD;
      end
    endcase
  end

  // Halfwords need an even offset, words need offset zero
  assign misaligned = ((size == HALF) && offset[0]) ||
                      ((size == WORD) && (offset != 2'd0));

  // Only a valid, aligned store reaches the memory
  assign st_en     = req.valid && is_store && !misaligned;
  assign st_size   = size;
  assign st_offset = offset;
  assign st_wdata  = req.wdata;

  // Context lines up with the registered memory read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_ctx <= '0;
    end else begin
      load_ctx.valid       <= req.valid;
      load_ctx.err         <= req.valid && misaligned;
      load_ctx.is_load     <= req.valid && is_load;
      load_ctx.size        <= size;
      load_ctx.is_unsigned <= is_unsigned;
      load_ctx.offset      <= offset;
    end
  end

endmodule

/* lsu_pkg.sv */
`include "lsu_config.svh"

package lsu_pkg;

  // Memory opcodes
  // Loads keep their RV32 funct3 codes, stores fill the free ones
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    SB  = 3'b011,
    LBU = 3'b100,
    LHU = 3'b101,
    SH  = 3'b110,
    SW  = 3'b111
  } mem_op_e;

  // Access width shared by both directions
  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } access_size_e;

  // Request from the core with one strobe per request
  typedef struct packed {
    logic                 valid;
    mem_op_e              op;
    // Byte address
    logic [`LSU_AW+1:0]   addr;
    logic [31:0]          wdata;
  } lsu_req_t;

  // Response exactly one cycle after its request
  typedef struct packed {
    logic        valid;
    logic        err;
    logic [31:0] rdata;
  } lsu_rsp_t;

  // Byte-strobed write command into the data memory
  typedef struct packed {
    logic               we;
    logic [`LSU_AW-1:0] word_addr;
    logic [3:0]         wstrb;
    logic [31:0]        wdata;
  } mem_wr_t;

  // Request state carried over to the response cycle
  typedef struct packed {
    logic         valid;
    logic         err;
    logic         is_load;
    access_size_e size;
    logic         is_unsigned;
    logic [1:0]   offset;
  } load_ctx_t;

endpackage

/* lsu_top.sv */
`include "lsu_config.svh"

module lsu_top (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::lsu_req_t req,
  output lsu_pkg::lsu_rsp_t rsp
);
  import lsu_pkg::*;

  // Store command from control to the aligner
  logic               st_en;
  access_size_e       st_size;
  logic [1:0]         st_offset;
  logic [31:0]        st_wdata;

  // Word address shared by the write and read ports
  logic [`LSU_AW-1:0] word_addr;

  // Datapath between the blocks
  mem_wr_t            mem_wr;
  logic [31:0]        rdata_word;
  load_ctx_t          load_ctx;

  // Decode, alignment check, context register
  lsu_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .st_en     (st_en),
    .st_size   (st_size),
    .st_offset (st_offset),
    .st_wdata  (st_wdata),
    .word_addr (word_addr),
    .load_ctx  (load_ctx)
  );

  // Lane shift and byte strobes
  store_align u_store_align (
    .st_en     (st_en),
    .size      (st_size),
    .offset    (st_offset),
    .wdata     (st_wdata),
    .word_addr (word_addr),
    .mem_wr    (mem_wr)
  );

  // Read address comes straight from the request
  data_mem u_data_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_wr     (mem_wr),
    .rd_addr    (word_addr),
    .rdata_word (rdata_word)
  );

  // Lane select and extension in the response cycle
  load_extract u_load_extract (
    .load_ctx   (load_ctx),
    .rdata_word (rdata_word),
    .rsp        (rsp)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_lsu -f lsu.f \
  && ./obj_dir/Vtb_lsu > sim.log 2>&1 \
  || echo "tests failed" >> sim.log

cat sim.log

# The log decides the verdict
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "FAIL: no pass message in log"; exit 1; }
echo "PASS"
exit 0

/* store_align.sv */
`include "lsu_config.svh"

module store_align (
  input  logic                  st_en,
  input  lsu_pkg::access_size_e size,
  input  logic [1:0]            offset,
  input  logic [31:0]           wdata,
  input  logic [`LSU_AW-1:0]    word_addr,
  output lsu_pkg::mem_wr_t      mem_wr
);
  import lsu_pkg::*;

  logic [31:0] lane_data;
  logic [3:0]  lane_strb;

  // Replicate the low bytes so every lane holds the right value
  // The strobe then picks which lanes land in memory
  always_comb begin
    unique case (size)
      BYTE: begin
        lane_data = {4{wdata[7:0]}};
        lane_strb = 4'b0001 << offset;
      end
      HALF: begin
        lane_data = {2{wdata[15:0]}};
        // Offset is 0 or 2 whenever st_en is high
        lane_strb = 4'b0011 << offset;
      end
      WORD: begin
        lane_data = wdata;
        lane_strb = 4'b1111;
      end
      default: begin
        lane_data = wdata;
        lane_strb = 4'b0000;
      end
    endcase
  end

  // Pack the write command
  // Alignment was already checked upstream
  always_comb begin
    mem_wr.we        = st_en;
    mem_wr.word_addr = word_addr;
    mem_wr.wstrb     = lane_strb;
    mem_wr.wdata     = lane_data;
  end

endmodule

/* tb_lsu.sv */
`include "lsu_config.svh"

module tb_lsu;
  import lsu_pkg::*;

  // Byte address width and shadow memory size follow the DUT
  localparam int BAW   = `LSU_AW + 2;
  localparam int BYTES = 4 * (2 ** `LSU_AW);

  // Request counts per test, used to size the timeout
  localparam int RESET_REQS  = 8;
  localparam int WORD_REQS   = 48;
  localparam int SUB_REQS    = 84;
  localparam int MIS_REQS    = 28;
  localparam int RAND_REQS   = 400;
  localparam int TOTAL_REQS  = RESET_REQS + WORD_REQS + SUB_REQS + MIS_REQS + RAND_REQS;
  localparam int CYCLE_LIMIT = 4 * TOTAL_REQS + `LSU_TIMEOUT_BASE;

  typedef logic [BAW-1:0] addr_t;
  typedef logic [7:0]     shadow_t [BYTES];

  logic     clk;
  logic     rst_n;
  lsu_req_t req;
  lsu_rsp_t rsp;

  // Byte image of what the memory should hold
  shadow_t  shadow;
  int       cycle_count = 0;

  // Outstanding responses, in issue order
  lsu_rsp_t exp_q [$];
  string    name_q [$];
  int       due_q [$];

  // Front entry as popped by the comparison process
  lsu_rsp_t exp_rsp;
  string    exp_name;
  int       exp_due;

  lsu_top uut (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Bytes touched by one access
  function automatic int access_bytes(input mem_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  function automatic logic is_store_op(input mem_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

  // Halfwords on even bytes, words on multiples of 4
  function automatic logic is_misaligned(input mem_op_e op, input addr_t addr);
    return (int'(addr) % access_bytes(op)) != 0;
  endfunction

  // Lanes of the addressed word that a store changes
  function automatic logic [3:0] store_lanes(input mem_op_e op, input addr_t addr);
    logic [3:0] lanes;
    int         off;
    lanes = 4'b0000;
    off   = int'(addr[1:0]);
    if (is_store_op(op) && !is_misaligned(op, addr)) begin
      for (int b = 0; b < 4; b++) begin
        if ((b >= off) && (b < off + access_bytes(op))) begin
          lanes[b] = 1'b1;
        end
      end
    end
    return lanes;
  endfunction

  // Expected response for one request against a memory image
  function automatic lsu_rsp_t expected_rsp(input mem_op_e op, input addr_t addr,
                                            input shadow_t mem);
    lsu_rsp_t r;
    logic [31:0] raw;
    int          nbytes;
    r.valid = 1'b1;
    r.err   = is_misaligned(op, addr);
    r.rdata = 32'h0;
    raw     = 32'h0;
    nbytes  = access_bytes(op);
    if (!r.err && !is_store_op(op)) begin
      // Little endian with the lowest address in the low byte
      for (int i = 0; i < nbytes; i++) begin
        raw[i*8 +: 8] = mem[int'(addr) + i];
      end
      // Signed loads copy the top bit of the access upward
      if ((op == LB) && raw[7]) begin
        raw[31:8] = '1;
      end
      if ((op == LH) && raw[15]) begin
        raw[31:16] = '1;
      end
      r.rdata = raw;
    end
    return r;
  endfunction

  // Store data low bytes land from the addressed byte upward
  function automatic void apply_store(input mem_op_e op, input addr_t addr,
                                      input logic [31:0] wdata);
    logic [3:0] lanes;
    int         base;
    int         off;
    lanes = store_lanes(op, addr);
    base  = int'(addr) & ~3;
    off   = int'(addr[1:0]);
    for (int b = 0; b < 4; b++) begin
      if (lanes[b]) begin
        shadow[base + b] = wdata[(b - off)*8 +: 8];
      end
    end
  endfunction

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      $display("tests failed");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // One request per call driven on the rising edge
  task automatic issue(input string name, input mem_op_e op, input addr_t addr,
                       input logic [31:0] wdata);
    lsu_rsp_t r;
    @(posedge clk);
    // Model sees memory as left by all earlier requests
    r = expected_rsp(op, addr, shadow);
    exp_q.push_back(r);
    name_q.push_back(name);
    // Sampled at the next edge and checked at the edge after
    due_q.push_back(cycle_count + 2);
    apply_store(op, addr, wdata);
    req.valid <= 1'b1;
    req.op    <= op;
    req.addr  <= addr;
    req.wdata <= wdata;
  endtask

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with responses still missing", CYCLE_LIMIT);
      $display("tests failed");
      $fatal(1, "timeout");
    end
  end

  // Comparison process that samples outputs before this edge updates them
  always @(posedge clk) begin
    if (!rst_n) begin
      // The context register is still unset at the first edge
      if ((cycle_count > 0) && (rsp.valid !== 1'b0)) begin
        stop_on_failure("Response strobe went high during reset");
      end
    end else if (rsp.valid) begin
      if (exp_q.size() == 0) begin
        stop_on_failure("Response arrived with no request outstanding");
      end else begin
        exp_rsp  = exp_q.pop_front();
        exp_name = name_q.pop_front();
        exp_due  = due_q.pop_front();
        if (exp_due != cycle_count) begin
          stop_on_failure({"Response for ", exp_name, " came in the wrong cycle"});
        end else begin
          check_value({exp_name, " err"}, {31'b0, exp_rsp.err}, {31'b0, rsp.err});
          check_value({exp_name, " rdata"}, exp_rsp.rdata, rsp.rdata);
        end
      end
    end else if ((due_q.size() != 0) && (due_q[0] <= cycle_count)) begin
      stop_on_failure({"No response one cycle after a request in ", name_q[0]});
    end
  end

  // Memory reads zero straight out of reset
  task automatic read_after_reset();
    for (int i = 0; i < RESET_REQS; i++) begin
      issue("reset_state", LW, addr_t'(i * 132), 32'h0);
    end
  endtask

  // Stores followed at once by loads and then a sweep over neighbours
  task automatic store_load_words();
    addr_t a;
    for (int i = 0; i < 16; i++) begin
      a = addr_t'(512 + i * 8);
      issue("word_access", SW, a, $urandom);
      issue("word_access", LW, a, 32'h0);
    end
    for (int i = 0; i < 16; i++) begin
      issue("word_access", LW, addr_t'(512 + i * 4), 32'h0);
    end
  endtask

  // Byte and halfword stores and loads at every legal offset
  task automatic subword_lanes();
    addr_t       a;
    logic [31:0] data;
    for (int w = 0; w < 4; w++) begin
      a = addr_t'(1024 + w * 4);
      issue("subword_access", SW, a, $urandom);
      for (int off = 0; off < 4; off++) begin
        data    = $urandom;
        // Alternate sign bits so both extensions show up
        data[7] = off[0];
        issue("subword_access", SB, a + addr_t'(off), data);
      end
      issue("subword_access", LW, a, 32'h0);
      for (int off = 0; off < 4; off++) begin
        issue("subword_access", LB, a + addr_t'(off), 32'h0);
      end
      for (int off = 0; off < 4; off++) begin
        issue("subword_access", LBU, a + addr_t'(off), 32'h0);
      end
      for (int off = 0; off < 4; off += 2) begin
        data     = $urandom;
        data[15] = off[1] ^ w[0];
        issue("subword_access", SH, a + addr_t'(off), data);
      end
      issue("subword_access", LW, a, 32'h0);
      for (int off = 0; off < 4; off += 2) begin
        issue("subword_access", LH, a + addr_t'(off), 32'h0);
      end
      for (int off = 0; off < 4; off += 2) begin
        issue("subword_access", LHU, a + addr_t'(off), 32'h0);
      end
    end
  endtask

  // Refused requests and then a load to prove nothing was written
  task automatic misaligned_refusal();
    addr_t a;
    for (int w = 0; w < 2; w++) begin
      a = addr_t'(1536 + w * 4);
      issue("misalignment", SW, a, $urandom);
      for (int off = 1; off < 4; off += 2) begin
        issue("misalignment", LH, a + addr_t'(off), 32'h0);
        issue("misalignment", LHU, a + addr_t'(off), 32'h0);
        issue("misalignment", SH, a + addr_t'(off), $urandom);
      end
      for (int off = 1; off < 4; off++) begin
        issue("misalignment", LW, a + addr_t'(off), 32'h0);
        issue("misalignment", SW, a + addr_t'(off), $urandom);
      end
      issue("misalignment", LW, a, 32'h0);
    end
  endtask

  // Back-to-back mix over 8 words so addresses collide
  task automatic random_traffic();
    logic [31:0] r;
    mem_op_e     op;
    addr_t       a;
    for (int i = 0; i < RAND_REQS; i++) begin
      r  = $urandom;
      op = mem_op_e'(r[2:0]);
      a  = addr_t'(256) + addr_t'(r[7:3]);
      issue("random_traffic", op, a, $urandom);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    req   = '0;
    void'($urandom(20368));
    for (int i = 0; i < BYTES; i++) begin
      shadow[i] = 8'h00;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    read_after_reset();
    store_load_words();
    subword_lanes();
    misaligned_refusal();
    random_traffic();

    // Idle the bus and let the last responses drain
    @(posedge clk);
    req.valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // A few quiet cycles catch any stray response
    repeat (3) @(posedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule
